/* tb.f */
rvTypes.sv
IdExBus.sv
Decoder_RV32I.sv
Controller_RV32I.sv
RegisterFile.sv
StageID.sv
StageEX.sv
RiscvCore.sv
tb_RiscvCore.sv

/* tb_RiscvCore.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_RiscvCore;

    localparam int TIMEOUT_CYCLES = 20;

    // One table entry with its expected outputs
    typedef struct {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] pc;
        logic        chkWr;    // Check rd and result
        logic [4:0]  rd;
        logic [31:0] result;
        logic [31:0] pcNext;
        logic        memWr;
        logic [31:0] memAddr;
        logic [31:0] memData;
    } Row;

    logic        clock, rstN, instValid;
    logic [31:0] inst, pc;
    logic        resultValid, memWrEnable;
    logic [4:0]  rdAddr;
    logic [31:0] result, pcNext, memAddr, memWrData;

    Row          rows[$];
    logic [31:0] rowPc;      // PC of the next table row
    logic [31:0] linkAddr;   // Link value of the JAL row

    RiscvCore u_dut (
        .i_Clock       (clock),
        .i_rstN        (rstN),
        .i_InstValid   (instValid),
        .i_Inst        (inst),
        .i_PC          (pc),
        .o_ResultValid (resultValid),
        .o_RdAddr      (rdAddr),
        .o_Result      (result),
        .o_PCNext      (pcNext),
        .o_MemWrEnable (memWrEnable),
        .o_MemAddr     (memAddr),
        .o_MemWrData   (memWrData));

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    // ------------------------------------------------------------------
    // RV32I instruction encoders
    // ------------------------------------------------------------------

    function automatic logic [31:0] encR(logic [6:0] f7, logic [2:0] f3,
                                         logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rvTypes::OpcOp};
    endfunction

    function automatic logic [31:0] encI(logic [6:0] opc, logic [2:0] f3,
                                         logic [4:0] rd, logic [4:0] rs1, logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, opc};  // Shamt and funct7 ride in imm
    endfunction

    function automatic logic [31:0] encS(logic [4:0] rs2, logic [4:0] rs1, logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvTypes::OpcStore};
    endfunction

    function automatic logic [31:0] encB(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvTypes::OpcBranch};
    endfunction

    function automatic logic [31:0] encJ(logic [4:0] rd, logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvTypes::OpcJal};
    endfunction

    // ------------------------------------------------------------------
    // Table building
    // ------------------------------------------------------------------

    task automatic addRow(logic valid, logic [31:0] code, logic chkWr, logic [4:0] rd,
                          logic [31:0] res, logic [31:0] nextPc, logic memWr,
                          logic [31:0] addr, logic [31:0] data);
        Row r;
        r = '{valid, code, rowPc, chkWr, rd, res, nextPc, memWr, addr, data};
        rows.push_back(r);
        rowPc = rowPc + 32'd4;
    endtask

    task automatic addAlu(logic [31:0] code, logic [4:0] rd, logic [31:0] res);
        addRow(1'b1, code, 1'b1, rd, res, rowPc + 32'd4, 1'b0, '0, '0);
    endtask

    task automatic addBranch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                             logic [31:0] imm, logic taken);
        addRow(1'b1, encB(f3, rs1, rs2, imm), 1'b0, '0, '0,
               taken ? rowPc + imm : rowPc + 32'd4, 1'b0, '0, '0);
    endtask

    task automatic addStore(logic [4:0] rs2, logic [4:0] rs1, logic [31:0] imm,
                            logic [31:0] addr, logic [31:0] data);
        addRow(1'b1, encS(rs2, rs1, imm), 1'b0, '0, '0, rowPc + 32'd4, 1'b1, addr, data);
    endtask

    task automatic addIdle(logic [31:0] code);
        addRow(1'b0, code, 1'b0, '0, '0, '0, 1'b0, '0, '0);  // Must not retire
    endtask

    task automatic buildTable();
        rowPc = 32'h100;
        // Fresh register file reads zero
        addAlu(encR(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0);
        addAlu(encR(7'h00, 3'b110, 5'd5, 5'd31, 5'd17), 5'd5, 32'h0);
        // Each row reads the previous rd
        addAlu(encI(rvTypes::OpcOpImm, 3'b000, 5'd1, 5'd0, 5), 5'd1, 32'd5);
        addAlu(encI(rvTypes::OpcOpImm, 3'b000, 5'd2, 5'd1, -3), 5'd2, 32'd2);
        addAlu(encR(7'h00, 3'b000, 5'd3, 5'd2, 5'd1), 5'd3, 32'd7);
        addAlu(encR(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), 5'd4, 32'd2);         // SUB
        addAlu({20'h80000, 5'd5, rvTypes::OpcLui}, 5'd5, 32'h8000_0000);
        addAlu(encR(7'h00, 3'b100, 5'd6, 5'd5, 5'd4), 5'd6, 32'h8000_0002); // XOR
        addAlu(encR(7'h00, 3'b110, 5'd7, 5'd6, 5'd3), 5'd7, 32'h8000_0007); // OR
        addAlu(encR(7'h00, 3'b111, 5'd8, 5'd7, 5'd1), 5'd8, 32'h5);         // AND
        addAlu(encR(7'h00, 3'b001, 5'd9, 5'd8, 5'd2), 5'd9, 32'h14);        // SLL
        addAlu(encR(7'h20, 3'b101, 5'd10, 5'd5, 5'd4), 5'd10, 32'hE000_0000); // SRA
        addAlu(encR(7'h00, 3'b101, 5'd11, 5'd10, 5'd1), 5'd11, 32'h0700_0000);
        addAlu(encR(7'h00, 3'b010, 5'd12, 5'd10, 5'd1), 5'd12, 32'h1);      // SLT
        addAlu(encR(7'h00, 3'b011, 5'd13, 5'd10, 5'd1), 5'd13, 32'h0);      // SLTU
        // Immediate forms
        addAlu(encI(rvTypes::OpcOpImm, 3'b001, 5'd14, 5'd1, 3), 5'd14, 32'h28);
        addAlu(encI(rvTypes::OpcOpImm, 3'b101, 5'd15, 5'd10, 32'h404), 5'd15, 32'hFE00_0000);
        addAlu(encI(rvTypes::OpcOpImm, 3'b101, 5'd16, 5'd10, 28), 5'd16, 32'hE);
        addAlu(encI(rvTypes::OpcOpImm, 3'b100, 5'd17, 5'd1, -1), 5'd17, 32'hFFFF_FFFA);
        addAlu(encI(rvTypes::OpcOpImm, 3'b111, 5'd18, 5'd17, 32'hF0), 5'd18, 32'hF0);
        addAlu(encI(rvTypes::OpcOpImm, 3'b110, 5'd19, 5'd18, 32'hF), 5'd19, 32'hFF);
        addAlu(encI(rvTypes::OpcOpImm, 3'b010, 5'd20, 5'd17, -5), 5'd20, 32'h1);
        addAlu(encI(rvTypes::OpcOpImm, 3'b011, 5'd21, 5'd1, -1), 5'd21, 32'h1);
        // Idle slot must leave x1 at 5
        addIdle(encI(rvTypes::OpcOpImm, 3'b000, 5'd1, 5'd0, 99));
        addAlu(encI(rvTypes::OpcOpImm, 3'b000, 5'd22, 5'd1, 0), 5'd22, 32'd5);
        // Negative x10 makes signed and unsigned compares disagree
        addBranch(3'b000, 5'd1, 5'd22, 16, 1'b1);   // BEQ
        addBranch(3'b000, 5'd2, 5'd3, 24, 1'b0);
        addBranch(3'b001, 5'd1, 5'd22, 16, 1'b0);   // BNE
        addBranch(3'b100, 5'd10, 5'd1, -8, 1'b1);   // BLT
        addBranch(3'b100, 5'd1, 5'd10, -12, 1'b0);
        addBranch(3'b110, 5'd10, 5'd1, 12, 1'b0);   // BLTU
        addBranch(3'b110, 5'd1, 5'd10, -16, 1'b1);
        addBranch(3'b101, 5'd10, 5'd1, 20, 1'b0);   // BGE
        addBranch(3'b101, 5'd1, 5'd10, 28, 1'b1);
        addBranch(3'b111, 5'd10, 5'd1, 20, 1'b1);   // BGEU
        addBranch(3'b111, 5'd1, 5'd10, -20, 1'b0);
        addBranch(3'b001, 5'd2, 5'd3, 8, 1'b1);
        // Jumps
        linkAddr = rowPc + 32'd4;
        addRow(1'b1, encJ(5'd23, 32'h100), 1'b1, 5'd23, linkAddr, rowPc + 32'h100,
               1'b0, '0, '0);
        addRow(1'b1, encI(rvTypes::OpcJalr, 3'b000, 5'd24, 5'd23, 3), 1'b1, 5'd24,
               rowPc + 32'd4, (linkAddr + 32'd3) & ~32'd1, 1'b0, '0, '0);
        addAlu(encR(7'h00, 3'b000, 5'd25, 5'd23, 5'd0), 5'd25, linkAddr);
        // Store rd fields overlap x12 and x28
        addStore(5'd3, 5'd1, 12, 32'd17, 32'd7);
        addStore(5'd17, 5'd10, -4, 32'hDFFF_FFFC, 32'hFFFF_FFFA);
        addAlu(encR(7'h00, 3'b000, 5'd26, 5'd12, 5'd0), 5'd26, 32'h1);
        // Result still reported for an x0 target
        addAlu(encI(rvTypes::OpcOpImm, 3'b000, 5'd0, 5'd1, 7), 5'd0, 32'd12);
        addAlu(encR(7'h00, 3'b000, 5'd27, 5'd0, 5'd1), 5'd27, 32'd5);
        addIdle(encR(7'h00, 3'b000, 5'd27, 5'd0, 5'd0));
        addAlu(encR(7'h00, 3'b000, 5'd28, 5'd28, 5'd27), 5'd28, 32'd5);
    endtask

    // ------------------------------------------------------------------
    // Drive and check
    // ------------------------------------------------------------------

    task automatic failRun(string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    task automatic driveRow(Row r);
        instValid = r.valid;
        inst      = r.inst;
        pc        = r.pc;
    endtask

    task automatic checkRow(Row r);
        checkValue("o_ResultValid", resultValid, r.valid);
        checkValue("o_MemWrEnable", memWrEnable, r.memWr);
        if (r.valid) begin
            checkValue("o_PCNext", pcNext, r.pcNext);
            if (r.chkWr) begin
                checkValue("o_RdAddr", rdAddr, r.rd);
                checkValue("o_Result", result, r.result);
            end
            if (r.memWr) begin
                checkValue("o_MemAddr", memAddr, r.memAddr);
                checkValue("o_MemWrData", memWrData, r.memData);
            end
        end
    endtask

    initial begin
        int waitCycles;
        rstN      = 1'b0;
        instValid = 1'b0;
        inst      = '0;
        pc        = '0;
        buildTable();

        repeat (16) @(posedge clock);
        @(negedge clock);
        checkValue("o_ResultValid", resultValid, 1'b0);  // Cleared by reset
        checkValue("o_MemWrEnable", memWrEnable, 1'b0);
        rstN = 1'b1;
        @(negedge clock);
        checkValue("o_ResultValid", resultValid, 1'b0);
        checkValue("o_MemWrEnable", memWrEnable, 1'b0);

        // One row per cycle with outputs checked a cycle later
        for (int i = 0; i < rows.size() - 1; i++) begin
            driveRow(rows[i]);
            @(negedge clock);
            checkRow(rows[i]);
        end

        driveRow(rows[rows.size() - 1]);
        waitCycles = 0;
        do begin
            @(negedge clock);
            waitCycles++;
        end while (!resultValid && waitCycles < TIMEOUT_CYCLES);
        if (!resultValid) begin
            failRun("timed out waiting for the last result");
        end
        checkValue("latency", waitCycles, 1);
        checkRow(rows[rows.size() - 1]);

        instValid = 1'b0;   // Pipeline drains
        @(negedge clock);
        checkValue("o_ResultValid", resultValid, 1'b0);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* RiscvCore.sv */
`timescale 1ns/10ps
`default_nettype none

module RiscvCore
#(
    parameter DATA_WIDTH = 32,
    parameter PC_WIDTH   = 32,
    parameter REG_WIDTH  = 5)
(
    input  logic                  i_Clock,
    input  logic                  i_rstN,
    input  logic                  i_InstValid,
    input  logic [31:0]           i_Inst,
    input  logic [PC_WIDTH-1:0]   i_PC,        // Supplied from outside, no fetch
    output logic                  o_ResultValid,
    output logic [REG_WIDTH-1:0]  o_RdAddr,
    output logic [DATA_WIDTH-1:0] o_Result,
    output logic [PC_WIDTH-1:0]   o_PCNext,
    output logic                  o_MemWrEnable,
    output logic [DATA_WIDTH-1:0] o_MemAddr,
    output logic [DATA_WIDTH-1:0] o_MemWrData);

    // Write-back loop from execute into the register file
    logic                  regWrEnable;
    logic [REG_WIDTH-1:0]  regWrAddr;
    logic [DATA_WIDTH-1:0] regWrData;

    IdExBus #(
        .DATA_WIDTH (DATA_WIDTH),
        .PC_WIDTH   (PC_WIDTH),
        .REG_WIDTH  (REG_WIDTH))
    idEx ();

    StageID #(
        .DATA_WIDTH (DATA_WIDTH),
        .PC_WIDTH   (PC_WIDTH),
        .REG_WIDTH  (REG_WIDTH))
    Id (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .i_InstValid   (i_InstValid),
        .i_Inst        (i_Inst),
        .i_PC          (i_PC),
        .i_RegWrEnable (regWrEnable),
        .i_RegWrAddr   (regWrAddr),
        .i_RegWrData   (regWrData),
        .o_Bus         (idEx));

    StageEX #(
        .DATA_WIDTH (DATA_WIDTH),
        .PC_WIDTH   (PC_WIDTH),
        .REG_WIDTH  (REG_WIDTH))
    Ex (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .i_Bus         (idEx),
        .o_RegWrEnable (regWrEnable),
        .o_RegWrAddr   (regWrAddr),
        .o_RegWrData   (regWrData),
        .o_ResultValid (o_ResultValid),
        .o_RdAddr      (o_RdAddr),
        .o_Result      (o_Result),
        .o_PCNext      (o_PCNext),
        .o_MemWrEnable (o_MemWrEnable),
        .o_MemAddr     (o_MemAddr),
        .o_MemWrData   (o_MemWrData));

endmodule

`default_nettype wire

/* StageEX.sv */
`timescale 1ns/10ps
`default_nettype none

module StageEX
#(
    parameter DATA_WIDTH = 32,
    parameter PC_WIDTH   = 32,
    parameter REG_WIDTH  = 5)
(
    input  logic                  i_Clock,
    input  logic                  i_rstN,
    IdExBus.sink                  i_Bus,
    // Write port, combinational from the current item
    output logic                  o_RegWrEnable,
    output logic [REG_WIDTH-1:0]  o_RegWrAddr,
    output logic [DATA_WIDTH-1:0] o_RegWrData,
    // Registered report
    output logic                  o_ResultValid,
    output logic [REG_WIDTH-1:0]  o_RdAddr,
    output logic [DATA_WIDTH-1:0] o_Result,
    output logic [PC_WIDTH-1:0]   o_PCNext,
    output logic                  o_MemWrEnable,
    output logic [DATA_WIDTH-1:0] o_MemAddr,
    output logic [DATA_WIDTH-1:0] o_MemWrData);

    localparam SHAMT_WIDTH = $clog2(DATA_WIDTH);

    logic [DATA_WIDTH-1:0]  aluResult;
    logic [DATA_WIDTH-1:0]  wbData;
    logic [SHAMT_WIDTH-1:0] shamt;

    assign shamt = i_Bus.dataB[SHAMT_WIDTH-1:0];

    // ------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------

    always_comb begin
        case (i_Bus.aluOp)
            rvTypes::AluAdd:   aluResult = i_Bus.dataA + i_Bus.dataB;  // Also store address
            rvTypes::AluSub:   aluResult = i_Bus.dataA - i_Bus.dataB;
            rvTypes::AluAnd:   aluResult = i_Bus.dataA & i_Bus.dataB;
            rvTypes::AluOr:    aluResult = i_Bus.dataA | i_Bus.dataB;
            rvTypes::AluXor:   aluResult = i_Bus.dataA ^ i_Bus.dataB;
            rvTypes::AluSll:   aluResult = i_Bus.dataA << shamt;
            rvTypes::AluSrl:   aluResult = i_Bus.dataA >> shamt;
            rvTypes::AluSra:   aluResult = DATA_WIDTH'($signed(i_Bus.dataA) >>> shamt);
            rvTypes::AluSlt:
                aluResult = DATA_WIDTH'($signed(i_Bus.dataA) < $signed(i_Bus.dataB));
            rvTypes::AluSltu:  aluResult = DATA_WIDTH'(i_Bus.dataA < i_Bus.dataB);
            rvTypes::AluPassB: aluResult = i_Bus.dataB;
            default:           aluResult = '0;
        endcase
    end

    // Link address for jumps
    assign wbData = (i_Bus.wbSel == rvTypes::WbPcPlus4) ? DATA_WIDTH'(i_Bus.pcPlus4)
                                                        : aluResult;

    assign o_RegWrEnable = i_Bus.valid & i_Bus.regWrEnable;
    assign o_RegWrAddr   = i_Bus.rdAddr;
    assign o_RegWrData   = wbData;

    // ------------------------------------------------------------------
    // Result register, one cycle latency
    // ------------------------------------------------------------------

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            o_ResultValid <= 1'b0;
            o_MemWrEnable <= 1'b0;
        end else begin
            o_ResultValid <= i_Bus.valid;                      // Drops on idle cycles
            o_MemWrEnable <= i_Bus.valid & i_Bus.memWrEnable;
        end
    end

    // Payload follows the bus every cycle
    always_ff @(posedge i_Clock) begin
        o_RdAddr    <= i_Bus.rdAddr;
        o_Result    <= wbData;
        o_PCNext    <= i_Bus.pcNext;
        o_MemAddr   <= aluResult;
        o_MemWrData <= i_Bus.memWrData;
    end

endmodule

`default_nettype wire

/* StageID.sv */
`timescale 1ns/10ps
`default_nettype none

module StageID
#(
    parameter DATA_WIDTH = 32,
    parameter PC_WIDTH   = 32,
    parameter REG_WIDTH  = 5)
(
    input  logic                  i_Clock,
    input  logic                  i_rstN,
    input  logic                  i_InstValid,
    input  logic [31:0]           i_Inst,
    input  logic [PC_WIDTH-1:0]   i_PC,
    // Write port back from execute
    input  logic                  i_RegWrEnable,
    input  logic [REG_WIDTH-1:0]  i_RegWrAddr,
    input  logic [DATA_WIDTH-1:0] i_RegWrData,
    IdExBus.source                o_Bus);

    // ------------------------------------------------------------------
    // Field split and control
    // ------------------------------------------------------------------

    logic [6:0]            decOp;
    logic [2:0]            decFunct3;
    logic                  decFunct7b5;
    logic [REG_WIDTH-1:0]  decRs1, decRs2, decRd;
    logic [DATA_WIDTH-1:0] decImm;

    Decoder_RV32I #(
        .DATA_WIDTH (DATA_WIDTH),
        .REG_WIDTH  (REG_WIDTH))
    Dec (
        .i_Inst     (i_Inst),
        .o_OP       (decOp),
        .o_Funct3   (decFunct3),
        .o_Funct7b5 (decFunct7b5),
        .o_RS1      (decRs1),
        .o_RS2      (decRs2),
        .o_RD       (decRd),
        .o_IMM      (decImm));

    logic          isEq, isLt, isLtu;  // Branch flags
    logic          ctrlRegWrEnable, ctrlMemWrEnable, ctrlOperandBSel;
    rvTypes::WbSel ctrlWbSel;
    rvTypes::AluOp ctrlAluOp;
    rvTypes::PcSel ctrlPcSel;

    Controller_RV32I Ctrl (
        .i_OP          (decOp),
        .i_Funct3      (decFunct3),
        .i_Funct7b5    (decFunct7b5),
        .i_IsEQ        (isEq),
        .i_IsLT        (isLt),
        .i_IsLTU       (isLtu),
        .o_RegWrEnable (ctrlRegWrEnable),
        .o_MemWrEnable (ctrlMemWrEnable),
        .o_OperandBSel (ctrlOperandBSel),
        .o_WbSel       (ctrlWbSel),
        .o_AluOp       (ctrlAluOp),
        .o_PCNextSel   (ctrlPcSel));

    // ------------------------------------------------------------------
    // Register file and branch compare
    // ------------------------------------------------------------------

    logic [DATA_WIDTH-1:0] rs1Data, rs2Data;

    RegisterFile #(
        .DATA_WIDTH (DATA_WIDTH),
        .REG_WIDTH  (REG_WIDTH))
    Regs (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_WrEnable (i_RegWrEnable),
        .i_WrAddr   (i_RegWrAddr),
        .i_WrData   (i_RegWrData),
        .i_RdAddrA  (decRs1),
        .o_RdDataA  (rs1Data),
        .i_RdAddrB  (decRs2),
        .o_RdDataB  (rs2Data));

    assign isEq  = (rs1Data == rs2Data);
    assign isLt  = ($signed(rs1Data) < $signed(rs2Data));
    assign isLtu = (rs1Data < rs2Data);

    // ------------------------------------------------------------------
    // Next PC candidates
    // ------------------------------------------------------------------

    logic [PC_WIDTH-1:0] pcPlus4, pcRelative, pcRegister;

    assign pcPlus4    = i_PC + PC_WIDTH'(4);
    assign pcRelative = i_PC + decImm[PC_WIDTH-1:0];
    assign pcRegister = (rs1Data[PC_WIDTH-1:0] + decImm[PC_WIDTH-1:0]) & ~PC_WIDTH'(1);

    always_comb begin
        o_Bus.valid       = i_InstValid;
        o_Bus.dataA       = rs1Data;
        o_Bus.dataB       = ctrlOperandBSel ? decImm : rs2Data;
        o_Bus.memWrData   = rs2Data;
        o_Bus.rdAddr      = decRd;
        o_Bus.regWrEnable = ctrlRegWrEnable & i_InstValid;  // Idle cycle writes nothing
        o_Bus.memWrEnable = ctrlMemWrEnable & i_InstValid;
        o_Bus.wbSel       = ctrlWbSel;
        o_Bus.aluOp       = ctrlAluOp;
        o_Bus.pcPlus4     = pcPlus4;
        case (ctrlPcSel)
            rvTypes::PcRelative: o_Bus.pcNext = pcRelative;
            rvTypes::PcRegister: o_Bus.pcNext = pcRegister;
            default:             o_Bus.pcNext = pcPlus4;
        endcase
    end

endmodule

`default_nettype wire

/* RegisterFile.sv */
`timescale 1ns/10ps
`default_nettype none

module RegisterFile
#(
    parameter DATA_WIDTH = 32,
    parameter REG_WIDTH  = 5)
(
    input  logic                  i_Clock,
    input  logic                  i_rstN,     // Sync, active low
    input  logic                  i_WrEnable,
    input  logic [REG_WIDTH-1:0]  i_WrAddr,
    input  logic [DATA_WIDTH-1:0] i_WrData,
    input  logic [REG_WIDTH-1:0]  i_RdAddrA,
    output logic [DATA_WIDTH-1:0] o_RdDataA,
    input  logic [REG_WIDTH-1:0]  i_RdAddrB,
    output logic [DATA_WIDTH-1:0] o_RdDataB);

    logic [DATA_WIDTH-1:0] regs [2**REG_WIDTH];

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            regs <= '{default: '0};
        end else if (i_WrEnable && (i_WrAddr != '0)) begin
            regs[i_WrAddr] <= i_WrData;  // x0 is never written
        end
    end

    // Asynchronous read, x0 stays at its reset value of zero
    assign o_RdDataA = regs[i_RdAddrA];
    assign o_RdDataB = regs[i_RdAddrB];

endmodule

`default_nettype wire

/* Controller_RV32I.sv */
`timescale 1ns/10ps
`default_nettype none

module Controller_RV32I (
    input  logic [6:0]    i_OP,
    input  logic [2:0]    i_Funct3,
    input  logic          i_Funct7b5,
    input  logic          i_IsEQ,         // rs1 == rs2
    input  logic          i_IsLT,         // rs1 < rs2 signed
    input  logic          i_IsLTU,        // rs1 < rs2 unsigned
    output logic          o_RegWrEnable,
    output logic          o_MemWrEnable,
    output logic          o_OperandBSel,  // 1 picks the immediate
    output rvTypes::WbSel o_WbSel,
    output rvTypes::AluOp o_AluOp,
    output rvTypes::PcSel o_PCNextSel);

    logic branchTaken;

    // ALU function from funct3, SUB only exists in register form
    function automatic rvTypes::AluOp aluFromFunct(input logic [2:0] funct3,
                                                   input logic       alt,
                                                   input logic       isReg);
        case (funct3)
            3'b000:  aluFromFunct = (alt && isReg) ? rvTypes::AluSub : rvTypes::AluAdd;
            3'b001:  aluFromFunct = rvTypes::AluSll;
            3'b010:  aluFromFunct = rvTypes::AluSlt;
            3'b011:  aluFromFunct = rvTypes::AluSltu;
            3'b100:  aluFromFunct = rvTypes::AluXor;
            3'b101:  aluFromFunct = alt ? rvTypes::AluSra : rvTypes::AluSrl;
            3'b110:  aluFromFunct = rvTypes::AluOr;
            default: aluFromFunct = rvTypes::AluAnd;
        endcase
    endfunction

    // Branch condition, odd funct3 is the negated form
    always_comb begin
        case (i_Funct3)
            3'b000:  branchTaken = i_IsEQ;   // BEQ
            3'b001:  branchTaken = !i_IsEQ;  // BNE
            3'b100:  branchTaken = i_IsLT;   // BLT
            3'b101:  branchTaken = !i_IsLT;  // BGE
            3'b110:  branchTaken = i_IsLTU;  // BLTU
            3'b111:  branchTaken = !i_IsLTU; // BGEU
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        // Defaults cover unknown opcodes
        o_RegWrEnable = 1'b0;
        o_MemWrEnable = 1'b0;
        o_OperandBSel = 1'b0;
        o_WbSel       = rvTypes::WbAlu;
        o_AluOp       = rvTypes::AluAdd;
        o_PCNextSel   = rvTypes::PcPlus4;

        case (i_OP)
            rvTypes::OpcOp: begin
                o_RegWrEnable = 1'b1;
                o_AluOp       = aluFromFunct(i_Funct3, i_Funct7b5, 1'b1);
            end
            rvTypes::OpcOpImm: begin
                o_RegWrEnable = 1'b1;
                o_OperandBSel = 1'b1;
                o_AluOp       = aluFromFunct(i_Funct3, i_Funct7b5, 1'b0);
            end
            rvTypes::OpcLui: begin
                o_RegWrEnable = 1'b1;
                o_OperandBSel = 1'b1;
                o_AluOp       = rvTypes::AluPassB;  // rd = immU
            end
            rvTypes::OpcJal: begin
                o_RegWrEnable = 1'b1;
                o_WbSel       = rvTypes::WbPcPlus4;
                o_PCNextSel   = rvTypes::PcRelative;
            end
            rvTypes::OpcJalr: begin
                o_RegWrEnable = 1'b1;
                o_OperandBSel = 1'b1;
                o_WbSel       = rvTypes::WbPcPlus4;
                o_PCNextSel   = rvTypes::PcRegister;
            end
            rvTypes::OpcBranch: begin
                o_AluOp     = rvTypes::AluSub;
                o_PCNextSel = branchTaken ? rvTypes::PcRelative : rvTypes::PcPlus4;
            end
            rvTypes::OpcStore: begin
                o_MemWrEnable = 1'b1;
                o_OperandBSel = 1'b1;   // Address = rs1 + immS
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* Decoder_RV32I.sv */
`timescale 1ns/10ps
`default_nettype none

module Decoder_RV32I
#(
    parameter DATA_WIDTH = 32,
    parameter REG_WIDTH  = 5)
(
    input  logic [31:0]           i_Inst,     // Instruction word
    output logic [6:0]            o_OP,       // Opcode
    output logic [2:0]            o_Funct3,
    output logic                  o_Funct7b5, // SUB / SRA select
    output logic [REG_WIDTH-1:0]  o_RS1,
    output logic [REG_WIDTH-1:0]  o_RS2,
    output logic [REG_WIDTH-1:0]  o_RD,
    output logic [DATA_WIDTH-1:0] o_IMM);     // Sign-extended immediate

    logic [31:0] immI, immS, immB, immU, immJ;
    logic [31:0] imm;

    // Fixed field positions
    assign o_OP       = i_Inst[6:0];
    assign o_Funct3   = i_Inst[14:12];
    assign o_Funct7b5 = i_Inst[30];
    assign o_RD       = i_Inst[7 +: REG_WIDTH];
    assign o_RS1      = i_Inst[15 +: REG_WIDTH];
    assign o_RS2      = i_Inst[20 +: REG_WIDTH];

    // One immediate per format, bit 31 is always the sign
    assign immI = {{20{i_Inst[31]}}, i_Inst[31:20]};  // Shamt lands in [4:0]
    assign immS = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
    assign immB = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7], i_Inst[30:25],
                   i_Inst[11:8], 1'b0};
    assign immU = {i_Inst[31:12], 12'b0};
    assign immJ = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12], i_Inst[20],
                   i_Inst[30:21], 1'b0};

    always_comb begin
        case (o_OP)
            rvTypes::OpcStore:  imm = immS;
            rvTypes::OpcBranch: imm = immB;
            rvTypes::OpcLui:    imm = immU;
            rvTypes::OpcJal:    imm = immJ;
            default:            imm = immI; // OP-IMM, JALR
        endcase
    end

    assign o_IMM = DATA_WIDTH'(signed'(imm));

endmodule

`default_nettype wire

/* IdExBus.sv */
`timescale 1ns/10ps
`default_nettype none

interface IdExBus
#(
    parameter DATA_WIDTH = 32,
    parameter PC_WIDTH   = 32,
    parameter REG_WIDTH  = 5);

    logic                  valid;       // Only handshake, no ready
    logic [DATA_WIDTH-1:0] dataA;       // rs1
    logic [DATA_WIDTH-1:0] dataB;       // rs2 or immediate
    logic [DATA_WIDTH-1:0] memWrData;   // Store data, always rs2
    logic [REG_WIDTH-1:0]  rdAddr;
    logic                  regWrEnable;
    logic                  memWrEnable;
    rvTypes::WbSel         wbSel;
    rvTypes::AluOp         aluOp;
    logic [PC_WIDTH-1:0]   pcPlus4;     // Link value
    logic [PC_WIDTH-1:0]   pcNext;      // Resolved in decode

    // Decode side drives everything
    modport source (output valid, dataA, dataB, memWrData, rdAddr, regWrEnable,
                    memWrEnable, wbSel, aluOp, pcPlus4, pcNext);

    // Execute side takes every valid item
    modport sink (input valid, dataA, dataB, memWrData, rdAddr, regWrEnable,
                  memWrEnable, wbSel, aluOp, pcPlus4, pcNext);

endinterface

`default_nettype wire

/* rvTypes.sv */
`default_nettype none

package rvTypes;

    // ------------------------------------------------------------------
    // Major opcodes, instruction bits [6:0]
    // ------------------------------------------------------------------

    localparam logic [6:0] OpcOp     = 7'b0110011; // Register-register ALU
    localparam logic [6:0] OpcOpImm  = 7'b0010011; // Register-immediate ALU
    localparam logic [6:0] OpcLui    = 7'b0110111;
    localparam logic [6:0] OpcJal    = 7'b1101111;
    localparam logic [6:0] OpcJalr   = 7'b1100111;
    localparam logic [6:0] OpcBranch = 7'b1100011; // BEQ .. BGEU
    localparam logic [6:0] OpcStore  = 7'b0100011; // Only SW is decoded

    // ------------------------------------------------------------------
    // Control encodings
    // ------------------------------------------------------------------

    // ALU operation, PASSB forwards operand B (LUI)
    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSll,
        AluSrl,
        AluSra,
        AluSlt,
        AluSltu,
        AluPassB
    } AluOp;

    // Source of the value written to rd
    typedef enum logic {
        WbAlu,
        WbPcPlus4   // Link address for JAL and JALR
    } WbSel;

    // Next PC source
    typedef enum logic [1:0] {
        PcPlus4,
        PcRelative, // PC + imm, taken branch and JAL
        PcRegister  // (rs1 + imm) & ~1, JALR
    } PcSel;

endpackage

`default_nettype wire
